// ==== flist.f ====
src/msePkg.sv
src/chanCfgIf.sv
src/mseRegs.sv
src/windowTimer.sv
src/errorAccumulator.sv
src/estimateSequencer.sv
src/dualMseEstimate.sv
testbench/dualMseTb_chk.sv
testbench/dualMseTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dual MSE estimator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dualMseTb -f flist.f -o dualMseSim

# keep running after an assertion error so the testbench can report it
./obj_dir/dualMseSim +verilator+error+limit+1000 | tee sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== testbench/dualMseTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualMseTb;

    localparam int NROWS = 10;
    localparam int NOEXP = 99999;

    logic clk;
    logic reset;
    logic cs;
    logic wr0;
    logic wr1;
    logic wr2;
    logic wr3;
    msePkg::busAddrT addr;
    msePkg::busDataT din;
    msePkg::busDataT dout;
    logic ch0SampleEn;
    logic ch1SampleEn;
    msePkg::magT ch0Mag;
    msePkg::magT ch1Mag;

    // stimulus table with one entry per test
    string rowName[NROWS];
    int rowCh[NROWS];
    int rowMean[NROWS];
    int rowExp[NROWS];
    int rowOffset[NROWS];
    int rowWindows[NROWS];
    int rowGap[NROWS];
    int rowMask[NROWS];
    int rowFixed[NROWS];
    int rowExpect[NROWS];
    bit rowPair[NROWS];
    bit rowRestart[NROWS];

    msePkg::magT ch0Samples[$];
    msePkg::magT ch1Samples[$];
    logic [15:0] lfsrState;
    int testErrors;
    int passCount;
    int failCount;
    int cycleCount;
    int cycleLimit;
    int assertFails;

    dualMseEstimate i_dut (
        .clk         (clk),
        .reset       (reset),
        .cs          (cs),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .addr        (addr),
        .din         (din),
        .dout        (dout),
        .ch0SampleEn (ch0SampleEn),
        .ch1SampleEn (ch1SampleEn),
        .ch0Mag      (ch0Mag),
        .ch1Mag      (ch1Mag)
    );

    bind estimateSequencer dualMseTb_chk seqChk (
        .clk         (clk),
        .reset       (reset),
        .restart     (restart),
        .resultValid (cfg.resultValid),
        .windowExp   (cfg.windowExp),
        .state       (state)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("run timed out after %0d cycles", cycleCount);
                $display("TEST FAILED");
                $finish;
            end
        end
    end

    task automatic setRow(input int r, input string name, input int ch, mean, exp, offset,
                          windows, gap, mask, fixedMag, expectVal, input bit pair, restart);
        rowName[r] = name;
        rowCh[r] = ch;
        rowMean[r] = mean;
        rowExp[r] = exp;
        rowOffset[r] = offset;
        rowWindows[r] = windows;
        rowGap[r] = gap;
        rowMask[r] = mask;
        rowFixed[r] = fixedMag;
        rowExpect[r] = expectVal;
        rowPair[r] = pair;
        rowRestart[r] = restart;
    endtask

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic msePkg::busAddrT regAddr(input msePkg::wordAddrT w);
        return {msePkg::DMSE_BASE, w};
    endfunction

    function automatic msePkg::wordAddrT cfgReg(input int ch);
        return (ch == 0) ? msePkg::REG_CH0_CFG : msePkg::REG_CH1_CFG;
    endfunction

    function automatic msePkg::wordAddrT offsetReg(input int ch);
        return (ch == 0) ? msePkg::REG_CH0_OFFSET : msePkg::REG_CH1_OFFSET;
    endfunction

    function automatic msePkg::wordAddrT resultReg(input int ch);
        return (ch == 0) ? msePkg::REG_CH0_RESULT : msePkg::REG_CH1_RESULT;
    endfunction

    function automatic msePkg::busDataT cfgWord(input int r);
        return (msePkg::busDataT'(rowExp[r]) << 16) | msePkg::busDataT'(rowMean[r]);
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // bus tasks start and end 2 ns after a rising edge
    task automatic busWrite(input msePkg::wordAddrT w, input msePkg::busDataT d,
                            input logic [3:0] strobes);
        cs = 1'b1;
        addr = regAddr(w);
        din = d;
        {wr3, wr2, wr1, wr0} = strobes;
        waitCycles(1);
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic busRead(input logic sel, input msePkg::busAddrT a,
                           output msePkg::busDataT d);
        cs = sel;
        addr = a;
        @(negedge clk);
        d = dout;
        waitCycles(1);
        cs = 1'b0;
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkWord(input string name, input msePkg::busDataT expected,
                             input msePkg::busDataT actual);
        assert (actual == expected) else begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic reportTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("%-12s passed", name);
        end else begin
            failCount++;
            $display("%-12s failed with %0d errors", name, testErrors);
        end
    endtask

    task automatic pushSample(input int ch, input msePkg::magT m);
        if (ch == 0) begin
            ch0Samples.push_back(m);
        end else begin
            ch1Samples.push_back(m);
        end
    endtask

    task automatic driveSample(input int ch, input logic en, input msePkg::magT m);
        if (ch == 0) begin
            ch0SampleEn = en;
            ch0Mag = m;
        end else begin
            ch1SampleEn = en;
            ch1Mag = m;
        end
    endtask

    task automatic streamSamples(input int ch, input int gap);
        msePkg::magT m;
        while ((ch == 0) ? (ch0Samples.size() > 0) : (ch1Samples.size() > 0)) begin
            if (ch == 0) begin
                m = ch0Samples.pop_front();
            end else begin
                m = ch1Samples.pop_front();
            end
            driveSample(ch, 1'b1, m);
            waitCycles(1);
            driveSample(ch, 1'b0, '0);
            waitCycles(gap);
        end
    endtask

    // queues the row's samples and returns the model value of its last window
    task automatic prepareRow(input int r, output int expected);
        int n;
        int raw;
        int mag;
        longint sum;
        longint val;
        n = 1 << rowExp[r];
        expected = 0;
        for (int w = 0; w < rowWindows[r]; w++) begin
            sum = 0;
            for (int k = 0; k < n; k++) begin
                drawBits(13, raw);
                mag = (rowFixed[r] >= 0) ? rowFixed[r] : (raw & rowMask[r]);
                pushSample(rowCh[r], msePkg::magT'(mag));
                sum += longint'((mag - rowMean[r]) * (mag - rowMean[r]));
            end
            val = (sum >> rowExp[r]) + longint'(rowOffset[r]);
            expected = (val > 32767) ? 32767 : ((val < -32768) ? -32768 : int'(val));
        end
        if (rowExpect[r] != NOEXP) begin
            expected = rowExpect[r];
        end
    endtask

    task automatic registerTest();
        msePkg::busDataT word;
        testErrors = 0;
        busWrite(msePkg::REG_CH0_OFFSET, 32'h1234_5678, 4'b1111);
        busRead(1'b1, regAddr(msePkg::REG_CH0_OFFSET), word);
        checkWord("reg_access", 32'h1234_5678, word);
        busWrite(msePkg::REG_CH0_OFFSET, 32'hAABB_CCDD, 4'b0010);
        busRead(1'b1, regAddr(msePkg::REG_CH0_OFFSET), word);
        checkWord("reg_access", 32'h1234_CC78, word);
        busWrite(msePkg::REG_CH0_OFFSET, 32'h9988_7766, 4'b1000);
        busRead(1'b1, regAddr(msePkg::REG_CH0_OFFSET), word);
        checkWord("reg_access", 32'h9934_CC78, word);
        busWrite(msePkg::REG_CH1_CFG, 32'h000A_1234, 4'b1111);
        busRead(1'b1, regAddr(msePkg::REG_CH1_CFG), word);
        checkWord("reg_access", 32'h000A_1234, word);
        busRead(1'b0, regAddr(msePkg::REG_CH1_CFG), word);
        checkWord("reg_access", 32'h0, word);
        busRead(1'b1, {msePkg::DMSE_BASE ^ 10'h001, msePkg::REG_CH1_CFG}, word);
        checkWord("reg_access", 32'h0, word);
        reportTest("reg_access");
    endtask

    task automatic runGroup(input int first, input int cnt);
        int expected[2];
        int startCount[2];
        int r;
        msePkg::busDataT word;
        for (int i = 0; i < cnt; i++) begin
            r = first + i;
            busWrite(offsetReg(rowCh[r]), msePkg::busDataT'(rowOffset[r]), 4'b1111);
            busWrite(cfgReg(rowCh[r]), cfgWord(r), 4'b1111);
        end
        waitCycles(3);
        for (int i = 0; i < cnt; i++) begin
            r = first + i;
            if (rowRestart[r]) begin
                // half a window of large samples, then dropped by the rewrite
                for (int k = 0; k < (1 << rowExp[r]) / 2; k++) begin
                    pushSample(rowCh[r], 13'h1FFF);
                end
                streamSamples(rowCh[r], rowGap[r]);
                busWrite(cfgReg(rowCh[r]), cfgWord(r), 4'b1111);
                waitCycles(3);
            end
            busRead(1'b1, regAddr(resultReg(rowCh[r])), word);
            startCount[i] = int'(word[23:16]);
            prepareRow(r, expected[i]);
        end
        if (cnt == 2) begin
            fork
                streamSamples(rowCh[first], rowGap[first]);
                streamSamples(rowCh[first + 1], rowGap[first + 1]);
            join
        end else begin
            streamSamples(rowCh[first], rowGap[first]);
        end
        for (int i = 0; i < cnt; i++) begin
            r = first + i;
            testErrors = 0;
            do begin
                busRead(1'b1, regAddr(resultReg(rowCh[r])), word);
            end while (word[23:16] != 8'(startCount[i] + rowWindows[r]));
            checkValue(rowName[r], expected[i], int'($signed(word[15:0])));
            reportTest(rowName[r]);
        end
    endtask

    initial begin
        int r;
        reset = 1'b1;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = '0;
        din = '0;
        ch0SampleEn = 1'b0;
        ch1SampleEn = 1'b0;
        ch0Mag = '0;
        ch1Mag = '0;
        lfsrState = 16'd75;
        passCount = 0;
        failCount = 0;
        //     row  name           ch mean  exp off     win gap mask     fixed  expect
        setRow(0, "exp0_random",  0, 100,  0, 0,      5,  1, 'hFF,   -1,   NOEXP, 0, 0);
        setRow(1, "exp3_random",  0, 200,  3, 100,    3,  2, 'hFF,   -1,   NOEXP, 0, 0);
        setRow(2, "exp6_random",  1, 64,   6, -50,    2,  0, 'h7F,   -1,   NOEXP, 0, 0);
        setRow(3, "sat_high",     0, 0,    2, 1000,   1,  0, 'h1FFF, 8191, 32767, 0, 0);
        setRow(4, "neg_offset",   1, 1234, 4, -1234,  2,  1, 'h1FFF, 1234, -1234, 0, 0);
        setRow(5, "dual_ch0",     0, 128,  2, 7,      3,  1, 'hFF,   -1,   NOEXP, 1, 0);
        setRow(6, "dual_ch1",     1, 40,   5, -3,     2,  3, 'h3F,   -1,   NOEXP, 0, 0);
        setRow(7, "b2b_exp0",     0, 0,    0, 0,      8,  0, 'h7F,   -1,   NOEXP, 0, 0);
        setRow(8, "b2b_exp1",     1, 60,   1, -20000, 6,  0, 'hFF,   -1,   NOEXP, 0, 0);
        setRow(9, "cfg_restart",  0, 30,   3, 5,      2,  1, 'h3F,   -1,   NOEXP, 0, 1);
        cycleLimit = 64;
        for (int i = 0; i < NROWS; i++) begin
            cycleLimit += rowWindows[i] * (1 << rowExp[i]) * (rowGap[i] + 1) + 64;
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        waitCycles(2);
        registerTest();
        r = 0;
        while (r < NROWS) begin
            if (rowPair[r]) begin
                runGroup(r, 2);
                r += 2;
            end else begin
                runGroup(r, 1);
                r += 1;
            end
        end
        waitCycles(4);
        assertFails = i_dut.ch0Seq.seqChk.failCount + i_dut.ch1Seq.seqChk.failCount;
        if (assertFails != 0) begin
            $display("checker reported %0d assertion failures", assertFails);
        end
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && assertFails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/dualMseTb_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualMseTb_chk (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              restart,
    input wire logic              resultValid,
    input wire msePkg::expT       windowExp,
    input wire msePkg::seqStateT  state
);

    int failCount = 0;

    // windows of two or more samples keep result pulses apart
    singlePulse: assert property (@(posedge clk) disable iff (reset)
        resultValid && windowExp != 4'd0 |=> !resultValid)
        else begin
            $error("resultValid high on two consecutive cycles");
            failCount++;
        end

    // timer and accumulator are flushed by restart, no window can finish for three cycles
    idleAfterRestart: assert property (@(posedge clk) disable iff (reset)
        $past(restart) || $past(restart, 2) || $past(restart, 3)
        |-> state == msePkg::SEQ_IDLE)
        else begin
            $error("sequencer not idle in the cycles after restart");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) reset |=> !resultValid)
        else begin
            $error("resultValid high during reset");
            failCount++;
        end

endmodule

`default_nettype wire

// ==== src/dualMseEstimate.sv ====
`timescale 1ns/1ps
`default_nettype none

module dualMseEstimate (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             cs,
    input  wire logic             wr0,
    input  wire logic             wr1,
    input  wire logic             wr2,
    input  wire logic             wr3,
    input  wire msePkg::busAddrT  addr,
    input  wire msePkg::busDataT  din,
    output msePkg::busDataT       dout,
    input  wire logic             ch0SampleEn,
    input  wire logic             ch1SampleEn,
    input  wire msePkg::magT      ch0Mag,
    input  wire msePkg::magT      ch1Mag
);

    logic inSpace;
    logic ch0Last;
    logic ch0Restart;
    logic ch0SumReady;
    msePkg::accT ch0WindowSum;
    logic ch1Last;
    logic ch1Restart;
    logic ch1SumReady;
    msePkg::accT ch1WindowSum;

    // block select on the upper address bits
    assign inSpace = cs &&
        (addr[msePkg::BUS_ADDR_W-1:msePkg::WORD_ADDR_W] == msePkg::DMSE_BASE);

    chanCfgIf ch0Cfg ();
    chanCfgIf ch1Cfg ();

    mseRegs regs (
        .clk      (clk),
        .reset    (reset),
        .inSpace  (inSpace),
        .wr0      (wr0),
        .wr1      (wr1),
        .wr2      (wr2),
        .wr3      (wr3),
        .wordAddr (addr[msePkg::WORD_ADDR_W-1:0]),
        .din      (din),
        .dout     (dout),
        .ch0Cfg   (ch0Cfg),
        .ch1Cfg   (ch1Cfg)
    );

    windowTimer ch0Timer (
        .clk        (clk),
        .reset      (reset),
        .sampleEn   (ch0SampleEn),
        .windowExp  (ch0Cfg.windowExp),
        .restart    (ch0Restart),
        .lastSample (ch0Last)
    );

    errorAccumulator ch0Accum (
        .clk        (clk),
        .reset      (reset),
        .sampleEn   (ch0SampleEn),
        .lastSample (ch0Last),
        .restart    (ch0Restart),
        .mag        (ch0Mag),
        .meanMag    (ch0Cfg.meanMag),
        .windowSum  (ch0WindowSum),
        .sumReady   (ch0SumReady)
    );

    estimateSequencer ch0Seq (
        .clk       (clk),
        .reset     (reset),
        .cfg       (ch0Cfg),
        .sumReady  (ch0SumReady),
        .windowSum (ch0WindowSum),
        .restart   (ch0Restart)
    );

    windowTimer ch1Timer (
        .clk        (clk),
        .reset      (reset),
        .sampleEn   (ch1SampleEn),
        .windowExp  (ch1Cfg.windowExp),
        .restart    (ch1Restart),
        .lastSample (ch1Last)
    );

    errorAccumulator ch1Accum (
        .clk        (clk),
        .reset      (reset),
        .sampleEn   (ch1SampleEn),
        .lastSample (ch1Last),
        .restart    (ch1Restart),
        .mag        (ch1Mag),
        .meanMag    (ch1Cfg.meanMag),
        .windowSum  (ch1WindowSum),
        .sumReady   (ch1SumReady)
    );

    estimateSequencer ch1Seq (
        .clk       (clk),
        .reset     (reset),
        .cfg       (ch1Cfg),
        .sumReady  (ch1SumReady),
        .windowSum (ch1WindowSum),
        .restart   (ch1Restart)
    );

endmodule

`default_nettype wire

// ==== src/estimateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module estimateSequencer (
    input  wire logic         clk,
    input  wire logic         reset,
    chanCfgIf.chan            cfg,
    input  wire logic         sumReady,
    input  wire msePkg::accT  windowSum,
    output logic              restart
);

    msePkg::seqStateT state;
    msePkg::accT finishSum;
    msePkg::accT windowMean;
    logic signed [msePkg::ACC_W:0] offsetSum;
    msePkg::resultT saturated;

    assign restart = cfg.cfgRestart;

    // idle until the first window since restart completes
    always_ff @(posedge clk) begin
        if (reset || cfg.cfgRestart) begin
            state <= msePkg::SEQ_IDLE;
        end else begin
            case (state)
                msePkg::SEQ_IDLE, msePkg::SEQ_ACCUM: begin
                    if (sumReady) begin
                        state <= msePkg::SEQ_FINISH;
                    end
                end
                msePkg::SEQ_FINISH: begin
                    // N=1 back to back stays in FINISH
                    if (sumReady) begin
                        state <= msePkg::SEQ_FINISH;
                    end else begin
                        state <= msePkg::SEQ_ACCUM;
                    end
                end
                default: state <= msePkg::SEQ_IDLE;
            endcase
        end
    end

    // the accumulator may overwrite windowSum while FINISH runs
    always_ff @(posedge clk) begin
        if (sumReady) begin
            finishSum <= windowSum;
        end
    end

    assign windowMean = finishSum >> cfg.windowExp;
    assign offsetSum = $signed({1'b0, windowMean}) + cfg.mseOffset;

    always_comb begin
        if (offsetSum > msePkg::RES_MAX) begin
            saturated = msePkg::RES_MAX;
        end else if (offsetSum < msePkg::RES_MIN) begin
            saturated = msePkg::RES_MIN;
        end else begin
            saturated = offsetSum[msePkg::RES_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || cfg.cfgRestart) begin
            cfg.resultValid <= 1'b0;
        end else begin
            cfg.resultValid <= (state == msePkg::SEQ_FINISH);
        end
    end

    always_ff @(posedge clk) begin
        if (state == msePkg::SEQ_FINISH) begin
            cfg.resultValue <= saturated;
        end
    end

endmodule

`default_nettype wire

// ==== src/errorAccumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module errorAccumulator (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         sampleEn,
    input  wire logic         lastSample,
    input  wire logic         restart,
    input  wire msePkg::magT  mag,
    input  wire msePkg::magT  meanMag,
    output msePkg::accT       windowSum,
    output logic              sumReady
);

    msePkg::errT sampleErr;
    msePkg::sqT errSquare;
    msePkg::accT runningSum;
    logic squareValid;
    logic squareLast;

    assign sampleErr = $signed({1'b0, mag}) - $signed({1'b0, meanMag});

    // stage 1, square of the error plus its window tag
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            errSquare <= sampleErr * sampleErr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            squareValid <= 1'b0;
            squareLast <= 1'b0;
        end else begin
            squareValid <= sampleEn;
            squareLast <= sampleEn && lastSample;
        end
    end

    // stage 2, running sum that starts over after the last sample
    always_ff @(posedge clk) begin
        if (reset || restart) begin
            runningSum <= '0;
            sumReady <= 1'b0;
        end else begin
            sumReady <= squareValid && squareLast;
            if (squareValid) begin
                if (squareLast) begin
                    runningSum <= '0;
                end else begin
                    runningSum <= runningSum + errSquare;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (squareValid && squareLast) begin
            windowSum <= runningSum + errSquare;
        end
    end

endmodule

`default_nettype wire

// ==== src/windowTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module windowTimer (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         sampleEn,
    input  wire msePkg::expT  windowExp,
    input  wire logic         restart,
    output logic              lastSample
);

    // one bit wider than MAX_EXP so that N = 2**15 still fits
    logic [msePkg::MAX_EXP:0] sampleCount;
    logic [msePkg::MAX_EXP:0] windowLen;

    assign windowLen = {{msePkg::MAX_EXP{1'b0}}, 1'b1} << windowExp;

    // last sample of the window sits at count N-1
    assign lastSample = sampleEn && (sampleCount == windowLen - 1'b1);

    always_ff @(posedge clk) begin
        if (reset || restart) begin
            sampleCount <= '0;
        end else if (sampleEn) begin
            if (lastSample) begin
                sampleCount <= '0;
            end else begin
                sampleCount <= sampleCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mseRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mseRegs (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              inSpace,
    input  wire logic              wr0,
    input  wire logic              wr1,
    input  wire logic              wr2,
    input  wire logic              wr3,
    input  wire msePkg::wordAddrT  wordAddr,
    input  wire msePkg::busDataT   din,
    output msePkg::busDataT        dout,
    chanCfgIf.regs                 ch0Cfg,
    chanCfgIf.regs                 ch1Cfg
);

    msePkg::busDataT ch0CfgWord;
    msePkg::busDataT ch0OffsetWord;
    msePkg::busDataT ch1CfgWord;
    msePkg::busDataT ch1OffsetWord;
    msePkg::resultT ch0Result;
    msePkg::resultT ch1Result;
    msePkg::winCountT ch0WinCount;
    msePkg::winCountT ch1WinCount;
    logic [3:0] byteWr;
    logic anyWr;

    assign byteWr = {wr3, wr2, wr1, wr0} & {4{inSpace}};
    assign anyWr = |byteWr;

    function automatic msePkg::busDataT mergeBytes(input msePkg::busDataT oldWord,
                                                   input msePkg::busDataT newWord,
                                                   input logic [3:0] strobes);
        msePkg::busDataT merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (strobes[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            ch0CfgWord <= '0;
            ch0OffsetWord <= '0;
            ch1CfgWord <= '0;
            ch1OffsetWord <= '0;
            ch0Cfg.cfgRestart <= 1'b0;
            ch1Cfg.cfgRestart <= 1'b0;
        end else begin
            if (wordAddr == msePkg::REG_CH0_CFG) begin
                ch0CfgWord <= mergeBytes(ch0CfgWord, din, byteWr);
            end
            if (wordAddr == msePkg::REG_CH0_OFFSET) begin
                ch0OffsetWord <= mergeBytes(ch0OffsetWord, din, byteWr);
            end
            if (wordAddr == msePkg::REG_CH1_CFG) begin
                ch1CfgWord <= mergeBytes(ch1CfgWord, din, byteWr);
            end
            if (wordAddr == msePkg::REG_CH1_OFFSET) begin
                ch1OffsetWord <= mergeBytes(ch1OffsetWord, din, byteWr);
            end
            // new settings take effect together with the restart pulse
            ch0Cfg.cfgRestart <= anyWr && (wordAddr == msePkg::REG_CH0_CFG ||
                                           wordAddr == msePkg::REG_CH0_OFFSET);
            ch1Cfg.cfgRestart <= anyWr && (wordAddr == msePkg::REG_CH1_CFG ||
                                           wordAddr == msePkg::REG_CH1_OFFSET);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ch0Result <= '0;
            ch0WinCount <= '0;
            ch1Result <= '0;
            ch1WinCount <= '0;
        end else begin
            if (ch0Cfg.resultValid) begin
                ch0Result <= ch0Cfg.resultValue;
                ch0WinCount <= ch0WinCount + 1'b1;
            end
            if (ch1Cfg.resultValid) begin
                ch1Result <= ch1Cfg.resultValue;
                ch1WinCount <= ch1WinCount + 1'b1;
            end
        end
    end

    assign ch0Cfg.meanMag = ch0CfgWord[12:0];
    assign ch0Cfg.windowExp = ch0CfgWord[19:16];
    assign ch0Cfg.mseOffset = ch0OffsetWord[15:0];
    assign ch1Cfg.meanMag = ch1CfgWord[12:0];
    assign ch1Cfg.windowExp = ch1CfgWord[19:16];
    assign ch1Cfg.mseOffset = ch1OffsetWord[15:0];

    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (wordAddr)
                msePkg::REG_CH0_CFG:    dout = ch0CfgWord;
                msePkg::REG_CH0_OFFSET: dout = ch0OffsetWord;
                msePkg::REG_CH0_RESULT: dout = {8'd0, ch0WinCount, ch0Result};
                msePkg::REG_CH1_CFG:    dout = ch1CfgWord;
                msePkg::REG_CH1_OFFSET: dout = ch1OffsetWord;
                msePkg::REG_CH1_RESULT: dout = {8'd0, ch1WinCount, ch1Result};
                default:                dout = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/chanCfgIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface chanCfgIf;

    msePkg::magT meanMag;
    msePkg::expT windowExp;
    msePkg::resultT mseOffset;
    // one cycle after a CFG or OFFSET write
    logic cfgRestart;
    logic resultValid;
    msePkg::resultT resultValue;

    modport regs (
        output meanMag,
        output windowExp,
        output mseOffset,
        output cfgRestart,
        input  resultValid,
        input  resultValue
    );

    modport chan (
        input  meanMag,
        input  windowExp,
        input  mseOffset,
        input  cfgRestart,
        output resultValid,
        output resultValue
    );

endinterface

`default_nettype wire

// ==== src/msePkg.sv ====
`default_nettype none

package msePkg;

    localparam int MAG_W = 13;
    localparam int ERR_W = 14;
    localparam int SQ_W = 27;
    localparam int MAX_EXP = 15;
    localparam int ACC_W = SQ_W + MAX_EXP;
    localparam int RES_W = 16;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_ADDR_W = 13;
    localparam int WORD_ADDR_W = 3;

    typedef logic [MAG_W-1:0] magT;
    typedef logic signed [ERR_W-1:0] errT;
    typedef logic [SQ_W-1:0] sqT;
    typedef logic [ACC_W-1:0] accT;
    typedef logic signed [RES_W-1:0] resultT;
    typedef logic [3:0] expT;
    typedef logic [7:0] winCountT;
    typedef logic [BUS_DATA_W-1:0] busDataT;
    typedef logic [BUS_ADDR_W-1:0] busAddrT;
    typedef logic [WORD_ADDR_W-1:0] wordAddrT;
    typedef logic [BUS_ADDR_W-WORD_ADDR_W-1:0] blockAddrT;

    // upper address bits that select the estimator block
    localparam blockAddrT DMSE_BASE = 10'h0C4;

    localparam wordAddrT REG_CH0_CFG = 3'd0;
    localparam wordAddrT REG_CH0_OFFSET = 3'd1;
    localparam wordAddrT REG_CH0_RESULT = 3'd2;
    localparam wordAddrT REG_CH1_CFG = 3'd4;
    localparam wordAddrT REG_CH1_OFFSET = 3'd5;
    localparam wordAddrT REG_CH1_RESULT = 3'd6;

    localparam resultT RES_MAX = 16'sh7FFF;
    localparam resultT RES_MIN = 16'sh8000;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_ACCUM, SEQ_FINISH} seqStateT;

endpackage

`default_nettype wire
